//--- verilog/bwt_job_pkg.sv
package bwt_job_pkg;

	// --------------------
	// job status codes
	// --------------------
	typedef enum logic [5:0] {
		F_INIT  = 6'h00, // first forward step, no interval yet
		F_RUN   = 6'h01,
		F_BREAK = 6'h02, // forward finished, result pending
		BCK_INI = 6'h04,
		BCK_RUN = 6'h05,
		BCK_END = 6'h06,
		BUBBLE  = 6'h30  // empty pipeline slot
	} job_status_e;

	// --------------------
	// query and read
	// --------------------
	localparam int unsigned READ_LEN  = 101;
	localparam int unsigned BASE_LAST = 3; // A C G T are 0..3, above is N

	typedef logic [6:0] pos_t;      // forward_i, min_intv, backward_x, ret
	typedef logic [7:0] base_t;
	typedef logic [9:0] read_num_t;

endpackage

//--- verilog/bwt_mem_pkg.sv
package bwt_mem_pkg;

	// --------------------
	// interval and queue words
	// --------------------
	typedef logic [63:0]  sa_idx_t;
	typedef logic [6:0]   curr_ptr_t;
	typedef logic [255:0] curr_entry_t; // {info, x2, x1, x0}

	// --------------------
	// occurrence table lines
	// --------------------
	typedef logic [31:0] dram_addr_t;

	localparam int unsigned OCC_LINE_LSB  = 7;  // 128 entries per line
	localparam int unsigned OCC_LINE_MSB  = 34;
	localparam int unsigned ADDR_PAD_BITS = 4;

endpackage

//--- verilog/fwd_entry_stage.sv
`timescale 1ns/1ps

module fwd_entry_stage (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  bwt_job_pkg::job_status_e status_i,
	input  bwt_job_pkg::base_t       query_i,
	input  bwt_mem_pkg::curr_ptr_t   ptr_curr_i,
	input  bwt_job_pkg::read_num_t   read_num_i,
	input  bwt_mem_pkg::sa_idx_t     ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  bwt_job_pkg::pos_t        forward_i_i, min_intv_i, backward_x_i,
	input  bwt_mem_pkg::sa_idx_t     ok_x0_i [4],
	input  bwt_mem_pkg::sa_idx_t     ok_x1_i [4],
	input  bwt_mem_pkg::sa_idx_t     ok_x2_i [4],
	output bwt_job_pkg::job_status_e status_o,
	output bwt_job_pkg::base_t       query_o,
	output bwt_mem_pkg::curr_ptr_t   ptr_curr_o,
	output bwt_job_pkg::read_num_t   read_num_o,
	output bwt_mem_pkg::sa_idx_t     ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output bwt_job_pkg::pos_t        forward_i_o, min_intv_o, backward_x_o,
	output bwt_mem_pkg::sa_idx_t     ok_x0_o [4],
	output bwt_mem_pkg::sa_idx_t     ok_x1_o [4],
	output bwt_mem_pkg::sa_idx_t     ok_x2_o [4]
);

	logic read_end; // whole read consumed

	assign read_end = (status_i == bwt_job_pkg::F_RUN) && (forward_i_i >= bwt_job_pkg::READ_LEN);

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_o <= bwt_job_pkg::BUBBLE;
		end else if (!stall_i) begin
			if (read_end) begin
				status_o <= bwt_job_pkg::F_BREAK;
			end else begin
				status_o <= status_i;
			end
			query_o      <= query_i;
			ptr_curr_o   <= ptr_curr_i;
			read_num_o   <= read_num_i;
			ik_x0_o      <= ik_x0_i;
			ik_x1_o      <= ik_x1_i;
			ik_x2_o      <= ik_x2_i;
			ik_info_o    <= ik_info_i;
			forward_i_o  <= forward_i_i;
			min_intv_o   <= min_intv_i;
			backward_x_o <= backward_x_i;
			ok_x0_o      <= ok_x0_i; // candidates from the occ unit
			ok_x1_o      <= ok_x1_i;
			ok_x2_o      <= ok_x2_i;
		end
	end

endmodule

//--- verilog/fwd_decide_stage.sv
`timescale 1ns/1ps

module fwd_decide_stage (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  bwt_job_pkg::job_status_e status_i,
	input  bwt_job_pkg::base_t       query_i,
	input  bwt_mem_pkg::curr_ptr_t   ptr_curr_i,
	input  bwt_job_pkg::read_num_t   read_num_i,
	input  bwt_mem_pkg::sa_idx_t     ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  bwt_job_pkg::pos_t        forward_i_i, min_intv_i, backward_x_i,
	input  bwt_mem_pkg::sa_idx_t     ok_x0_i [4],
	input  bwt_mem_pkg::sa_idx_t     ok_x1_i [4],
	input  bwt_mem_pkg::sa_idx_t     ok_x2_i [4],
	output bwt_job_pkg::job_status_e status_o,
	output bwt_mem_pkg::curr_ptr_t   ptr_curr_o,
	output bwt_job_pkg::read_num_t   read_num_o,
	output bwt_mem_pkg::sa_idx_t     ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output bwt_job_pkg::pos_t        forward_i_o, min_intv_o, backward_x_o,
	output bwt_mem_pkg::sa_idx_t     cand_x0_o, cand_x1_o, cand_x2_o,
	output logic                     update_ik_o,
	output logic                     advance_i_o,
	output logic                     curr_we_o,
	output bwt_mem_pkg::curr_ptr_t   curr_addr_o,
	output bwt_mem_pkg::curr_entry_t curr_data_o,
	output bwt_job_pkg::read_num_t   curr_read_num_o,
	output logic                     ret_valid_o,
	output bwt_job_pkg::pos_t        ret_o,
	output bwt_job_pkg::read_num_t   ret_read_num_o
);

	logic [1:0]               sel;       // candidate index
	logic                     ambiguous;
	logic                     push;      // old ik goes to the curr queue
	logic                     brk;
	logic                     step;      // interval taken, keep extending
	logic                     finish;
	bwt_mem_pkg::sa_idx_t     pick_x0, pick_x1, pick_x2;
	bwt_mem_pkg::curr_entry_t ik_entry;

	// --------------------
	// candidate and break decision
	// --------------------
	assign sel       = 2'd3 - query_i[1:0]; // complement base
	assign ambiguous = query_i > bwt_job_pkg::BASE_LAST;
	assign pick_x0   = ok_x0_i[sel];
	assign pick_x1   = ok_x1_i[sel];
	assign pick_x2   = ok_x2_i[sel];
	assign ik_entry  = {ik_info_i, ik_x2_i, ik_x1_i, ik_x0_i};
	assign finish    = status_i == bwt_job_pkg::F_BREAK;

	always_comb begin
		push = 1'b0;
		brk  = 1'b0;
		if (status_i == bwt_job_pkg::F_RUN) begin
			push = ambiguous || (pick_x2 != ik_x2_i); // interval shrinks
			brk  = ambiguous || (pick_x2 < min_intv_i);
		end else if (finish) begin
			push = forward_i_i == bwt_job_pkg::READ_LEN; // whole read matched
		end
	end

	assign step = (status_i == bwt_job_pkg::F_RUN) && push && !brk;

	// --------------------
	// registers
	// --------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_o        <= bwt_job_pkg::BUBBLE;
			update_ik_o     <= 1'b0;
			advance_i_o     <= 1'b0;
			curr_we_o       <= 1'b0;
			curr_addr_o     <= '0;
			curr_data_o     <= '0;
			curr_read_num_o <= '0;
			ret_valid_o     <= 1'b0;
			ret_o           <= '0;
			ret_read_num_o  <= '0;
		end else if (!stall_i) begin
			if (finish) begin
				status_o <= bwt_job_pkg::BCK_INI; // hand over to backward phase
			end else if (status_i == bwt_job_pkg::F_RUN && push && brk) begin
				status_o <= bwt_job_pkg::F_BREAK;
			end else begin
				status_o <= status_i;
			end
			update_ik_o     <= step;
			advance_i_o     <= step;
			curr_we_o       <= push;
			curr_addr_o     <= push ? ptr_curr_i : '0;
			curr_data_o     <= push ? ik_entry : '0;
			curr_read_num_o <= push ? read_num_i : '0;
			ptr_curr_o      <= push ? ptr_curr_i + 1'b1 : ptr_curr_i;
			ret_valid_o     <= finish;
			ret_o           <= finish ? ik_info_i[6:0] : '0; // info holds the end position
			ret_read_num_o  <= finish ? read_num_i : '0;
			cand_x0_o       <= pick_x0;
			cand_x1_o       <= pick_x1;
			cand_x2_o       <= pick_x2;
			read_num_o      <= read_num_i;
			ik_x0_o         <= ik_x0_i;
			ik_x1_o         <= ik_x1_i;
			ik_x2_o         <= ik_x2_i;
			ik_info_o       <= ik_info_i;
			forward_i_o     <= forward_i_i;
			min_intv_o      <= min_intv_i;
			backward_x_o    <= backward_x_i;
		end
	end

endmodule

//--- verilog/fwd_update_stage.sv
`timescale 1ns/1ps

module fwd_update_stage (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  bwt_job_pkg::job_status_e status_i,
	input  bwt_mem_pkg::curr_ptr_t   ptr_curr_i,
	input  bwt_job_pkg::read_num_t   read_num_i,
	input  bwt_mem_pkg::sa_idx_t     ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  bwt_job_pkg::pos_t        forward_i_i, min_intv_i, backward_x_i,
	input  bwt_mem_pkg::sa_idx_t     cand_x0_i, cand_x1_i, cand_x2_i,
	input  logic                     update_ik_i,
	input  logic                     advance_i_i,
	output bwt_job_pkg::job_status_e status_o,
	output bwt_mem_pkg::curr_ptr_t   ptr_curr_o,
	output bwt_job_pkg::read_num_t   read_num_o,
	output bwt_mem_pkg::sa_idx_t     ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output bwt_job_pkg::pos_t        forward_i_o, min_intv_o, backward_x_o,
	output bwt_mem_pkg::sa_idx_t     k_pre_o, l_pre_o,
	output bwt_mem_pkg::sa_idx_t     k_pre_m1_o, l_pre_m1_o
);

	logic                 take;
	bwt_mem_pkg::sa_idx_t nxt_x0, nxt_x1, nxt_x2, nxt_info;
	bwt_mem_pkg::sa_idx_t k_pre, l_pre;

	// --------------------
	// next interval
	// --------------------
	assign take     = (status_i == bwt_job_pkg::F_RUN) && update_ik_i;
	assign nxt_x0   = take ? cand_x0_i : ik_x0_i;
	assign nxt_x1   = take ? cand_x1_i : ik_x1_i;
	assign nxt_x2   = take ? cand_x2_i : ik_x2_i;
	assign nxt_info = take ? bwt_mem_pkg::sa_idx_t'(forward_i_i) + 64'd1 : ik_info_i;

	assign k_pre = nxt_x1 - 64'd1;  // occ rows are one below x1
	assign l_pre = k_pre + nxt_x2;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_o <= bwt_job_pkg::BUBBLE;
		end else if (!stall_i) begin
			status_o     <= status_i;
			ptr_curr_o   <= ptr_curr_i;
			read_num_o   <= read_num_i;
			ik_x0_o      <= nxt_x0;
			ik_x1_o      <= nxt_x1;
			ik_x2_o      <= nxt_x2;
			ik_info_o    <= nxt_info;
			forward_i_o  <= advance_i_i ? forward_i_i + 1'b1 : forward_i_i; // i++
			min_intv_o   <= min_intv_i;
			backward_x_o <= backward_x_i;
			k_pre_o      <= k_pre;
			l_pre_o      <= l_pre;
			k_pre_m1_o   <= k_pre - 64'd1; // ready in case primary is crossed
			l_pre_m1_o   <= l_pre - 64'd1;
		end
	end

endmodule

//--- verilog/occ_request_stage.sv
`timescale 1ns/1ps

module occ_request_stage (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  bwt_mem_pkg::sa_idx_t     primary_i,
	input  bwt_job_pkg::job_status_e status_i,
	input  bwt_mem_pkg::curr_ptr_t   ptr_curr_i,
	input  bwt_job_pkg::read_num_t   read_num_i,
	input  bwt_mem_pkg::sa_idx_t     ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  bwt_job_pkg::pos_t        forward_i_i, min_intv_i, backward_x_i,
	input  bwt_mem_pkg::sa_idx_t     k_pre_i, l_pre_i,
	input  bwt_mem_pkg::sa_idx_t     k_pre_m1_i, l_pre_m1_i,
	output logic                     dram_valid_o,
	output bwt_mem_pkg::dram_addr_t  addr_k_o, addr_l_o,
	output bwt_job_pkg::job_status_e status_o,
	output bwt_mem_pkg::curr_ptr_t   ptr_curr_o,
	output bwt_job_pkg::read_num_t   read_num_o,
	output bwt_mem_pkg::sa_idx_t     ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output bwt_job_pkg::pos_t        forward_i_o, min_intv_o, backward_x_o,
	output bwt_job_pkg::pos_t        next_query_position_o
);

	logic                    fwd_req; // forward job needs occ lines
	bwt_mem_pkg::sa_idx_t    k_fix, l_fix;
	bwt_mem_pkg::dram_addr_t line_k, line_l;

	// primary row is absent from the occ table
	assign k_fix   = (k_pre_i >= primary_i) ? k_pre_m1_i : k_pre_i;
	assign l_fix   = (l_pre_i >= primary_i) ? l_pre_m1_i : l_pre_i;
	assign line_k  = {k_fix[bwt_mem_pkg::OCC_LINE_MSB:bwt_mem_pkg::OCC_LINE_LSB],
		{bwt_mem_pkg::ADDR_PAD_BITS{1'b0}}};
	assign line_l  = {l_fix[bwt_mem_pkg::OCC_LINE_MSB:bwt_mem_pkg::OCC_LINE_LSB],
		{bwt_mem_pkg::ADDR_PAD_BITS{1'b0}}};
	assign fwd_req = (status_i == bwt_job_pkg::F_INIT) || (status_i == bwt_job_pkg::F_RUN);

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_o     <= bwt_job_pkg::BUBBLE;
			dram_valid_o <= 1'b0;
			addr_k_o     <= '0;
			addr_l_o     <= '0;
		end else if (!stall_i) begin
			dram_valid_o <= fwd_req;
			addr_k_o     <= fwd_req ? line_k : '0;
			addr_l_o     <= fwd_req ? line_l : '0;
			if (status_i == bwt_job_pkg::F_INIT) begin
				status_o <= bwt_job_pkg::F_RUN; // first request issued
			end else begin
				status_o <= status_i;
			end
			ptr_curr_o            <= ptr_curr_i;
			read_num_o            <= read_num_i;
			ik_x0_o               <= ik_x0_i;
			ik_x1_o               <= ik_x1_i;
			ik_x2_o               <= ik_x2_i;
			ik_info_o             <= ik_info_i;
			forward_i_o           <= forward_i_i;
			min_intv_o            <= min_intv_i;
			backward_x_o          <= backward_x_i;
			next_query_position_o <= forward_i_i;
		end
	end

endmodule

//--- verilog/fwd_ext_datapath.sv
`timescale 1ns/1ps

module fwd_ext_datapath (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  bwt_mem_pkg::sa_idx_t     primary_i,
	input  bwt_job_pkg::job_status_e status_i,
	input  bwt_job_pkg::base_t       query_i,
	input  bwt_mem_pkg::curr_ptr_t   ptr_curr_i,
	input  bwt_job_pkg::read_num_t   read_num_i,
	input  bwt_mem_pkg::sa_idx_t     ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i,
	input  bwt_job_pkg::pos_t        forward_i_i, min_intv_i, backward_x_i,
	input  bwt_mem_pkg::sa_idx_t     ok_x0_i [4],
	input  bwt_mem_pkg::sa_idx_t     ok_x1_i [4],
	input  bwt_mem_pkg::sa_idx_t     ok_x2_i [4],
	output logic                     dram_valid_o,
	output bwt_mem_pkg::dram_addr_t  addr_k_o, addr_l_o,
	output bwt_job_pkg::job_status_e status_o,
	output bwt_mem_pkg::curr_ptr_t   ptr_curr_o,
	output bwt_job_pkg::read_num_t   read_num_o,
	output bwt_mem_pkg::sa_idx_t     ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o,
	output bwt_job_pkg::pos_t        forward_i_o, min_intv_o, backward_x_o,
	output bwt_job_pkg::pos_t        next_query_position_o,
	output logic                     curr_we_o,
	output bwt_mem_pkg::curr_ptr_t   curr_addr_o,
	output bwt_mem_pkg::curr_entry_t curr_data_o,
	output bwt_job_pkg::read_num_t   curr_read_num_o,
	output logic                     ret_valid_o,
	output bwt_job_pkg::pos_t        ret_o,
	output bwt_job_pkg::read_num_t   ret_read_num_o
);

	// --------------------
	// stage 1 to 3 job fields
	// --------------------
	bwt_job_pkg::job_status_e status_s1, status_s2, status_s3;
	bwt_job_pkg::base_t       query_s1;
	bwt_mem_pkg::curr_ptr_t   ptr_curr_s1, ptr_curr_s2, ptr_curr_s3;
	bwt_job_pkg::read_num_t   read_num_s1, read_num_s2, read_num_s3;
	bwt_mem_pkg::sa_idx_t     ik_x0_s1, ik_x1_s1, ik_x2_s1, ik_info_s1;
	bwt_mem_pkg::sa_idx_t     ik_x0_s2, ik_x1_s2, ik_x2_s2, ik_info_s2;
	bwt_mem_pkg::sa_idx_t     ik_x0_s3, ik_x1_s3, ik_x2_s3, ik_info_s3;
	bwt_job_pkg::pos_t        forward_i_s1, min_intv_s1, backward_x_s1;
	bwt_job_pkg::pos_t        forward_i_s2, min_intv_s2, backward_x_s2;
	bwt_job_pkg::pos_t        forward_i_s3, min_intv_s3, backward_x_s3;
	bwt_mem_pkg::sa_idx_t     ok_x0_s1 [4];
	bwt_mem_pkg::sa_idx_t     ok_x1_s1 [4];
	bwt_mem_pkg::sa_idx_t     ok_x2_s1 [4];
	bwt_mem_pkg::sa_idx_t     cand_x0_s2, cand_x1_s2, cand_x2_s2;
	logic                     update_ik_s2, advance_i_s2;
	bwt_mem_pkg::sa_idx_t     k_pre_s3, l_pre_s3, k_pre_m1_s3, l_pre_m1_s3;

	fwd_entry_stage u_entry (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.status_i(status_i), .query_i(query_i), .ptr_curr_i(ptr_curr_i),
		.read_num_i(read_num_i), .ik_x0_i(ik_x0_i), .ik_x1_i(ik_x1_i),
		.ik_x2_i(ik_x2_i), .ik_info_i(ik_info_i), .forward_i_i(forward_i_i),
		.min_intv_i(min_intv_i), .backward_x_i(backward_x_i),
		.ok_x0_i(ok_x0_i), .ok_x1_i(ok_x1_i), .ok_x2_i(ok_x2_i),
		.status_o(status_s1), .query_o(query_s1), .ptr_curr_o(ptr_curr_s1),
		.read_num_o(read_num_s1), .ik_x0_o(ik_x0_s1), .ik_x1_o(ik_x1_s1),
		.ik_x2_o(ik_x2_s1), .ik_info_o(ik_info_s1), .forward_i_o(forward_i_s1),
		.min_intv_o(min_intv_s1), .backward_x_o(backward_x_s1),
		.ok_x0_o(ok_x0_s1), .ok_x1_o(ok_x1_s1), .ok_x2_o(ok_x2_s1)
	);

	fwd_decide_stage u_decide (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.status_i(status_s1), .query_i(query_s1), .ptr_curr_i(ptr_curr_s1),
		.read_num_i(read_num_s1), .ik_x0_i(ik_x0_s1), .ik_x1_i(ik_x1_s1),
		.ik_x2_i(ik_x2_s1), .ik_info_i(ik_info_s1), .forward_i_i(forward_i_s1),
		.min_intv_i(min_intv_s1), .backward_x_i(backward_x_s1),
		.ok_x0_i(ok_x0_s1), .ok_x1_i(ok_x1_s1), .ok_x2_i(ok_x2_s1),
		.status_o(status_s2), .ptr_curr_o(ptr_curr_s2), .read_num_o(read_num_s2),
		.ik_x0_o(ik_x0_s2), .ik_x1_o(ik_x1_s2), .ik_x2_o(ik_x2_s2),
		.ik_info_o(ik_info_s2), .forward_i_o(forward_i_s2), .min_intv_o(min_intv_s2),
		.backward_x_o(backward_x_s2), .cand_x0_o(cand_x0_s2), .cand_x1_o(cand_x1_s2),
		.cand_x2_o(cand_x2_s2), .update_ik_o(update_ik_s2), .advance_i_o(advance_i_s2),
		.curr_we_o(curr_we_o), .curr_addr_o(curr_addr_o), .curr_data_o(curr_data_o),
		.curr_read_num_o(curr_read_num_o), .ret_valid_o(ret_valid_o), .ret_o(ret_o),
		.ret_read_num_o(ret_read_num_o)
	);

	fwd_update_stage u_update (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.status_i(status_s2), .ptr_curr_i(ptr_curr_s2), .read_num_i(read_num_s2),
		.ik_x0_i(ik_x0_s2), .ik_x1_i(ik_x1_s2), .ik_x2_i(ik_x2_s2),
		.ik_info_i(ik_info_s2), .forward_i_i(forward_i_s2), .min_intv_i(min_intv_s2),
		.backward_x_i(backward_x_s2), .cand_x0_i(cand_x0_s2), .cand_x1_i(cand_x1_s2),
		.cand_x2_i(cand_x2_s2), .update_ik_i(update_ik_s2), .advance_i_i(advance_i_s2),
		.status_o(status_s3), .ptr_curr_o(ptr_curr_s3), .read_num_o(read_num_s3),
		.ik_x0_o(ik_x0_s3), .ik_x1_o(ik_x1_s3), .ik_x2_o(ik_x2_s3),
		.ik_info_o(ik_info_s3), .forward_i_o(forward_i_s3), .min_intv_o(min_intv_s3),
		.backward_x_o(backward_x_s3), .k_pre_o(k_pre_s3), .l_pre_o(l_pre_s3),
		.k_pre_m1_o(k_pre_m1_s3), .l_pre_m1_o(l_pre_m1_s3)
	);

	occ_request_stage u_request (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.primary_i(primary_i), .status_i(status_s3), .ptr_curr_i(ptr_curr_s3),
		.read_num_i(read_num_s3), .ik_x0_i(ik_x0_s3), .ik_x1_i(ik_x1_s3),
		.ik_x2_i(ik_x2_s3), .ik_info_i(ik_info_s3), .forward_i_i(forward_i_s3),
		.min_intv_i(min_intv_s3), .backward_x_i(backward_x_s3),
		.k_pre_i(k_pre_s3), .l_pre_i(l_pre_s3),
		.k_pre_m1_i(k_pre_m1_s3), .l_pre_m1_i(l_pre_m1_s3),
		.dram_valid_o(dram_valid_o), .addr_k_o(addr_k_o), .addr_l_o(addr_l_o),
		.status_o(status_o), .ptr_curr_o(ptr_curr_o), .read_num_o(read_num_o),
		.ik_x0_o(ik_x0_o), .ik_x1_o(ik_x1_o), .ik_x2_o(ik_x2_o), .ik_info_o(ik_info_o),
		.forward_i_o(forward_i_o), .min_intv_o(min_intv_o), .backward_x_o(backward_x_o),
		.next_query_position_o(next_query_position_o)
	);

endmodule

//--- test/fwd_ext_model.svh
// --------------------
// expected curr queue and ret ports, two cycles after the job
// --------------------
typedef struct packed {
	logic [2:0]               kind; // behavior group of the job
	logic                     chk;
	logic                     we;
	bwt_mem_pkg::curr_ptr_t   addr;
	bwt_mem_pkg::curr_entry_t data;
	bwt_job_pkg::read_num_t   crn;
	logic                     rv;
	bwt_job_pkg::pos_t        ret;
	bwt_job_pkg::read_num_t   rrn;
} near_exp_t;

// --------------------
// expected job write-back and DRAM request, four cycles after the job
// --------------------
typedef struct packed {
	logic [2:0]               kind;
	logic                     chk;
	bwt_job_pkg::job_status_e status;
	logic                     dv;
	bwt_mem_pkg::dram_addr_t  ak, al;
	bwt_mem_pkg::curr_ptr_t   ptr;
	bwt_job_pkg::read_num_t   rn;
	bwt_mem_pkg::sa_idx_t     x0, x1, x2, info;
	bwt_job_pkg::pos_t        fi, mi, bx; // next query position equals fi
} far_exp_t;

task automatic predict_job(output near_exp_t n, output far_exp_t f);
	bwt_job_pkg::job_status_e st;
	logic [1:0]               c;
	logic                     amb, shrink, brk, upd;
	bwt_mem_pkg::sa_idx_t     k, l;
	n = '0;
	f = '0;
	shrink = 1'b0;
	upd = 1'b0;
	n.kind = 3'd4;
	st = status_i;
	if (st == bwt_job_pkg::F_RUN && forward_i_i >= bwt_job_pkg::READ_LEN)
		st = bwt_job_pkg::F_BREAK; // read end reached
	c = 2'd3 - query_i[1:0];
	if (st == bwt_job_pkg::F_RUN) begin
		n.kind = 3'd1;
		amb = query_i > 8'd3;
		shrink = amb || (ok_x2_i[c] != ik_x2_i);
		brk = amb || (ok_x2_i[c] < {57'd0, min_intv_i});
		if (shrink && brk) begin
			st = bwt_job_pkg::F_BREAK;
			n.kind = 3'd2;
		end else begin
			upd = shrink;
		end
	end else if (st == bwt_job_pkg::F_BREAK) begin
		n.kind = (status_i == bwt_job_pkg::F_RUN) ? 3'd2 : 3'd3;
		shrink = forward_i_i == bwt_job_pkg::READ_LEN;
		n.rv = 1'b1;
		n.ret = ik_info_i[6:0];
		n.rrn = read_num_i;
		st = bwt_job_pkg::BCK_INI;
	end
	f = {n.kind, 1'b0, st, 1'b0, 64'd0, ptr_curr_i, read_num_i, ik_x0_i, ik_x1_i,
		ik_x2_i, ik_info_i, forward_i_i, min_intv_i, backward_x_i};
	if (shrink) begin
		n.we = 1'b1;
		n.addr = ptr_curr_i;
		n.data = {ik_info_i, ik_x2_i, ik_x1_i, ik_x0_i};
		n.crn = read_num_i;
		f.ptr = ptr_curr_i + 7'd1;
	end
	if (upd) begin
		f.x0 = ok_x0_i[c];
		f.x1 = ok_x1_i[c];
		f.x2 = ok_x2_i[c];
		f.info = {57'd0, forward_i_i} + 64'd1;
		f.fi = forward_i_i + 7'd1;
	end
	k = f.x1 - 64'd1;
	l = k + f.x2;
	if (k >= primary_i) k = k - 64'd1; // skip primary row
	if (l >= primary_i) l = l - 64'd1;
	f.dv = (st == bwt_job_pkg::F_INIT) || (st == bwt_job_pkg::F_RUN);
	if (f.dv) begin
		f.ak = {k[bwt_mem_pkg::OCC_LINE_MSB:bwt_mem_pkg::OCC_LINE_LSB], 4'd0};
		f.al = {l[bwt_mem_pkg::OCC_LINE_MSB:bwt_mem_pkg::OCC_LINE_LSB], 4'd0};
	end
	f.status = (st == bwt_job_pkg::F_INIT) ? bwt_job_pkg::F_RUN : st;
endtask

//--- test/tb_fwd_ext.sv
`timescale 1ns/1ps

module tb_fwd_ext;

	localparam int JOBS        = 400;
	localparam int CYCLE_LIMIT = 2 * JOBS + 100;

	logic Clk_32UI, reset_BWT_extend, stall_i;
	bwt_mem_pkg::sa_idx_t     primary_i, ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i;
	bwt_job_pkg::job_status_e status_i, status_o;
	bwt_job_pkg::base_t       query_i;
	bwt_mem_pkg::curr_ptr_t   ptr_curr_i, ptr_curr_o, curr_addr_o;
	bwt_job_pkg::read_num_t   read_num_i, read_num_o, curr_read_num_o, ret_read_num_o;
	bwt_job_pkg::pos_t        forward_i_i, min_intv_i, backward_x_i, ret_o;
	bwt_job_pkg::pos_t        forward_i_o, min_intv_o, backward_x_o, next_query_position_o;
	bwt_mem_pkg::sa_idx_t     ok_x0_i [4], ok_x1_i [4], ok_x2_i [4];
	bwt_mem_pkg::sa_idx_t     ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o;
	bwt_mem_pkg::dram_addr_t  addr_k_o, addr_l_o;
	bwt_mem_pkg::curr_entry_t curr_data_o;
	logic dram_valid_o, curr_we_o, ret_valid_o;
	logic [663:0] out_now, out_snap; // every DUT output side by side

	`include "fwd_ext_model.svh"

	integer    seed;
	int        cycles, pass_cnt, err_cnt, done_jobs, sent_jobs, stalls;
	int        kind_jobs [6], kind_errs [6];
	near_exp_t next_near, e_near, q_near [$];
	far_exp_t  next_far, e_far, q_far [$];

	fwd_ext_datapath dut0 (.*);

	assign out_now = {dram_valid_o, addr_k_o, addr_l_o, status_o, ptr_curr_o, read_num_o,
		ik_x0_o, ik_x1_o, ik_x2_o, ik_info_o, forward_i_o, min_intv_o, backward_x_o,
		next_query_position_o, curr_we_o, curr_addr_o, curr_data_o, curr_read_num_o,
		ret_valid_o, ret_o, ret_read_num_o};

	function automatic int unsigned rand_below(input int unsigned n);
		int unsigned r;
		r = $unsigned($random(seed));
		return r % n;
	endfunction

	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic check_val(input string name, input logic [255:0] exp_v,
			input logic [255:0] act_v, input int kind);
		if (act_v !== exp_v) begin
			$display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp_v, act_v);
			err_cnt++;
			kind_errs[kind]++;
		end else begin
			pass_cnt++;
		end
	endtask

	// --------------------
	// random job near the read end and primary
	// --------------------
	task automatic make_job(input logic real_job);
		int j;
		int unsigned mode;
		status_i = bwt_job_pkg::BUBBLE; // drain slots
		if (real_job) begin
			case (rand_below(8))
				0: status_i = bwt_job_pkg::F_INIT;
				1, 2, 3, 4: status_i = bwt_job_pkg::F_RUN;
				5: status_i = bwt_job_pkg::F_BREAK;
				6: status_i = bwt_job_pkg::BCK_INI;
				default: status_i = bwt_job_pkg::BUBBLE;
			endcase
			query_i = 8'(rand_below(5));
			ptr_curr_i = 7'(rand_below(128));
			read_num_i = 10'(rand_below(1024));
			forward_i_i = 7'(rand_below(3) == 0 ? 100 + rand_below(3) : rand_below(101));
			min_intv_i = 7'(1 + rand_below(20));
			backward_x_i = 7'(rand_below(128));
			ik_x0_i = rand64();
			ik_x1_i = rand_below(2) ? primary_i - 64'd3 + rand_below(6) : rand64();
			ik_x2_i = 64'(rand_below(300));
			ik_info_i = rand64();
			for (j = 0; j < 4; j++) begin
				mode = rand_below(3);
				ok_x0_i[j] = rand64();
				ok_x1_i[j] = rand_below(2) ? primary_i - 64'd4 + rand_below(9) : rand64();
				ok_x2_i[j] = (mode == 0) ? ik_x2_i : (mode == 1) ? 64'(rand_below(min_intv_i))
					: 64'(min_intv_i + rand_below(500));
			end
			sent_jobs++;
		end
		predict_job(next_near, next_far);
		next_near.chk = real_job;
		next_far.chk = real_job;
	endtask

	initial begin
		Clk_32UI = 1'b0;
		forever #10 Clk_32UI = ~Clk_32UI;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge Clk_32UI);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		seed = 32'h27f3_063f;
		{pass_cnt, err_cnt, done_jobs, sent_jobs, stalls} = '0;
		foreach (kind_jobs[k])
			{kind_jobs[k], kind_errs[k]} = '0;
		reset_BWT_extend = 1'b0;
		stall_i = 1'b0;
		// on a line boundary so the skipped primary row moves the line
		primary_i = 64'(1 + rand_below(32'h00ff_ffff)) << bwt_mem_pkg::OCC_LINE_LSB;
		{query_i, ptr_curr_i, read_num_i, forward_i_i, min_intv_i, backward_x_i} = '0;
		{ik_x0_i, ik_x1_i, ik_x2_i, ik_info_i} = '0;
		ok_x0_i = '{default: '0};
		ok_x1_i = '{default: '0};
		ok_x2_i = '{default: '0};
		status_i = bwt_job_pkg::BUBBLE;
		repeat (8) @(posedge Clk_32UI);
		#1;
		check_val("status_o", bwt_job_pkg::BUBBLE, status_o, 0);
		check_val("curr_we_o", 0, curr_we_o, 0);
		check_val("ret_valid_o", 0, ret_valid_o, 0);
		check_val("dram_valid_o", 0, dram_valid_o, 0);
		check_val("curr_addr_o", 0, curr_addr_o, 0);
		check_val("curr_data_o", 0, curr_data_o, 0);
		check_val("curr_read_num_o", 0, curr_read_num_o, 0);
		$display("reset: %0d errors", kind_errs[0]);
		reset_BWT_extend = 1'b1;
		make_job(1'b1);
		stall_i = rand_below(8) == 0;
		out_snap = out_now;
		while (done_jobs < JOBS) begin
			@(posedge Clk_32UI);
			#1;
			if (stall_i) begin
				stalls++;
				if (out_now !== out_snap) begin
					$display("mismatch at %0t ns: outputs during stall expected %0h got %0h",
						$time, out_snap, out_now);
					err_cnt++;
					kind_errs[5]++;
				end else begin
					pass_cnt++;
				end
			end else begin
				q_near.push_back(next_near);
				q_far.push_back(next_far);
				if (q_near.size() == 2) begin
					e_near = q_near.pop_front();
					if (e_near.chk) begin
						check_val("curr_we_o", e_near.we, curr_we_o, e_near.kind);
						check_val("curr_addr_o", e_near.addr, curr_addr_o, e_near.kind);
						check_val("curr_data_o", e_near.data, curr_data_o, e_near.kind);
						check_val("curr_read_num_o", e_near.crn, curr_read_num_o, e_near.kind);
						check_val("ret_valid_o", e_near.rv, ret_valid_o, e_near.kind);
						check_val("ret_o", e_near.ret, ret_o, e_near.kind);
						check_val("ret_read_num_o", e_near.rrn, ret_read_num_o, e_near.kind);
					end
				end
				if (q_far.size() == 4) begin
					e_far = q_far.pop_front();
					if (e_far.chk) begin
						check_val("status_o", e_far.status, status_o, e_far.kind);
						check_val("dram_valid_o", e_far.dv, dram_valid_o, e_far.kind);
						check_val("addr_k_o", e_far.ak, addr_k_o, e_far.kind);
						check_val("addr_l_o", e_far.al, addr_l_o, e_far.kind);
						check_val("ptr_curr_o", e_far.ptr, ptr_curr_o, e_far.kind);
						check_val("read_num_o", e_far.rn, read_num_o, e_far.kind);
						check_val("ik_x0_o", e_far.x0, ik_x0_o, e_far.kind);
						check_val("ik_x1_o", e_far.x1, ik_x1_o, e_far.kind);
						check_val("ik_x2_o", e_far.x2, ik_x2_o, e_far.kind);
						check_val("ik_info_o", e_far.info, ik_info_o, e_far.kind);
						check_val("forward_i_o", e_far.fi, forward_i_o, e_far.kind);
						check_val("min_intv_o", e_far.mi, min_intv_o, e_far.kind);
						check_val("backward_x_o", e_far.bx, backward_x_o, e_far.kind);
						check_val("next_query_position_o", e_far.fi, next_query_position_o,
							e_far.kind);
						kind_jobs[e_far.kind]++;
						done_jobs++;
					end
				end
				make_job(sent_jobs < JOBS);
			end
			out_snap = out_now;
			stall_i = rand_below(8) == 0; // about one cycle in eight
		end
		$display("running step: %0d jobs, %0d errors", kind_jobs[1], kind_errs[1]);
		$display("breaks: %0d jobs, %0d errors", kind_jobs[2], kind_errs[2]);
		$display("finished job: %0d jobs, %0d errors", kind_jobs[3], kind_errs[3]);
		$display("other statuses: %0d jobs, %0d errors", kind_jobs[4], kind_errs[4]);
		$display("stall and latency: %0d stalls, %0d errors", stalls, kind_errs[5]);
		$display("checks passed: %0d, errors: %0d", pass_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+test
verilog/bwt_job_pkg.sv
verilog/bwt_mem_pkg.sv
verilog/fwd_entry_stage.sv
verilog/fwd_decide_stage.sv
verilog/fwd_update_stage.sv
verilog/occ_request_stage.sv
verilog/fwd_ext_datapath.sv
test/tb_fwd_ext.sv
